// ==== source/bm_pkg.sv ====
`default_nettype none

package bm_pkg;

    // ----------------------------------------
    // widths and depths
    // ----------------------------------------
    localparam int W_SIZE      = 10;
    localparam int W_CHANNEL   = 10;

    localparam int FM_AW       = 12;
    localparam int FM_DEPTH    = 1 << FM_AW;    // 4096 words per buffer
    localparam int FM_DW       = 32;

    localparam int FILT_AW     = 9;
    localparam int FILT_DEPTH  = 1 << FILT_AW;  // 512 kernels per filter
    localparam int FILT_DW     = 72;            // 3x3 of 8-bit weights

    localparam int AXI_DW      = 32;
    localparam int NUM_FILTERS = 4;             // one byte lane each
    localparam int KERNEL_TAPS = 9;

    // ----------------------------------------
    // scalar types
    // ----------------------------------------
    typedef logic [W_SIZE-1:0]    size_t;
    typedef logic [W_CHANNEL-1:0] chan_t;
    typedef logic [FM_AW-1:0]     fm_addr_t;
    typedef logic [FM_DW-1:0]     fm_data_t;
    typedef logic [FILT_AW-1:0]   filt_addr_t;
    typedef logic [FILT_DW-1:0]   filt_data_t;
    typedef logic [AXI_DW-1:0]    axi_data_t;

    typedef enum logic {
        ROLE_IFM = 1'b0,
        ROLE_OFM = 1'b1
    } fm_role_e;

    // ----------------------------------------
    // bundles
    // ----------------------------------------
    typedef struct packed {
        logic     en;
        fm_addr_t addr;
        fm_data_t data;
    } fm_wr_t;

    typedef struct packed {
        logic     en;
        fm_addr_t addr;
    } fm_rd_t;

    typedef struct packed {
        size_t      width;
        size_t      height;
        chan_t      channel;      // input channels set the filter count
        chan_t      channel_out;
        logic       maxpool;
        logic [1:0] maxpool_stride;
        logic       upsample;
    } layer_cfg_t;

endpackage

`default_nettype wire

// ==== source/sdp_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module sdp_ram #(
    parameter int AW = 12,
    parameter int DW = 32
) (
    input  wire          clk,

    // write side
    input  wire          wr_en,
    input  wire [AW-1:0] wr_addr,
    input  wire [DW-1:0] wr_data,

    // read side
    input  wire          rd_en,
    input  wire [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_data
);

    logic [DW-1:0] mem [0:(1<<AW)-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency and holds the last word when idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/ifm_axi_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module ifm_axi_loader (
    input  wire                  clk,
    input  wire                  rstn,

    input  wire                  load,
    input  wire bm_pkg::axi_data_t read_data,
    input  wire                  read_data_vld,

    output bm_pkg::fm_wr_t       ifm_wr,
    output logic                 active
);

    logic              load_d;
    logic              load_start;
    logic              wr_en;
    bm_pkg::fm_addr_t  wr_addr;
    bm_pkg::fm_data_t  wr_data;

    assign load_start = load & ~load_d;

    // ----------------------------------------
    // beat capture and address counter
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_d  <= 1'b0;
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            load_d <= load;
            wr_en  <= load & read_data_vld;     // written one edge later

            if (load_start) begin
                wr_addr <= '0;                  // every load starts at 0
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= read_data;
    end

    assign ifm_wr.en   = wr_en;
    assign ifm_wr.addr = wr_addr;
    assign ifm_wr.data = wr_data;

    // lines up with the registered write stream
    assign active = load_d;

endmodule

`default_nettype wire

// ==== source/fm_pingpong.sv ====
`timescale 1ns/100ps
`default_nettype none

module fm_pingpong (
    input  wire                     clk,
    input  wire                     rstn,

    input  wire bm_pkg::layer_cfg_t cfg,
    input  wire                     buf_switch,   // swap ifm/ofm roles

    // ifm load from axi into buffer 0 only
    input  wire bm_pkg::fm_wr_t     load_wr,
    input  wire                     load_active,

    // result writes
    input  wire bm_pkg::fm_wr_t     ofm_wr,

    // ifm tap
    input  wire bm_pkg::fm_rd_t     tap_rd,
    output bm_pkg::fm_data_t        tap_rdata,

    output logic                    ofm_done
);

    bm_pkg::fm_role_e  role      [2];
    bm_pkg::fm_wr_t    buf_wr    [2];
    bm_pkg::fm_rd_t    buf_rd    [2];
    bm_pkg::fm_data_t  buf_rdata [2];
    logic              rd_sel;              // buffer that served the last tap read

    bm_pkg::size_t     eff_w;
    bm_pkg::size_t     eff_h;
    logic [2*bm_pkg::W_SIZE+bm_pkg::W_CHANNEL-1:0] ofm_count;
    bm_pkg::fm_addr_t  ofm_last_addr;

    // ----------------------------------------
    // role pointers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            role[0] <= bm_pkg::ROLE_IFM;
            role[1] <= bm_pkg::ROLE_OFM;
        end else if (buf_switch) begin
            role[0] <= role[1];
            role[1] <= role[0];
        end
    end

    // ----------------------------------------
    // write and read steering
    // ----------------------------------------
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            buf_wr[b] = (role[b] == bm_pkg::ROLE_OFM) ? ofm_wr : '0;
            buf_rd[b] = (role[b] == bm_pkg::ROLE_IFM) ? tap_rd : '0;
        end

        // loader wins buffer 0 while a load runs
        if (load_active) begin
            buf_wr[0] = load_wr;
        end
    end

    // remember the source so a switch in flight
    // does not pick the wrong word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_sel <= 1'b0;
        end else if (tap_rd.en) begin
            rd_sel <= (role[1] == bm_pkg::ROLE_IFM);
        end
    end

    assign tap_rdata = rd_sel ? buf_rdata[1] : buf_rdata[0];

    for (genvar b = 0; b < 2; b++) begin : g_fm_buf
        sdp_ram #(
            .AW (bm_pkg::FM_AW),
            .DW (bm_pkg::FM_DW)
        ) u_fm_ram (
            .clk     (clk),
            .wr_en   (buf_wr[b].en),
            .wr_addr (buf_wr[b].addr),
            .wr_data (buf_wr[b].data),
            .rd_en   (buf_rd[b].en),
            .rd_addr (buf_rd[b].addr),
            .rd_data (buf_rdata[b])
        );
    end

    // ----------------------------------------
    // ofm done
    // ----------------------------------------
    always_comb begin
        if (cfg.maxpool && (cfg.maxpool_stride == 2'd2)) begin
            eff_w = cfg.width >> 1;
            eff_h = cfg.height >> 1;
        end else if (cfg.upsample) begin
            eff_w = cfg.width << 1;
            eff_h = cfg.height << 1;
        end else begin
            eff_w = cfg.width;
            eff_h = cfg.height;
        end
    end

    assign ofm_count     = eff_w * eff_h * cfg.channel_out;
    assign ofm_last_addr = bm_pkg::fm_addr_t'(ofm_count - 1'b1);

    assign ofm_done = ofm_wr.en && (ofm_wr.addr == ofm_last_addr);

endmodule

`default_nettype wire

// ==== source/filter_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

module filter_packer (
    input  wire                      clk,
    input  wire                      rstn,

    input  wire                      load,
    input  wire bm_pkg::chan_t       channel,
    input  wire bm_pkg::axi_data_t   read_data,
    input  wire                      read_data_vld,

    output logic                     wr_en,
    output bm_pkg::filt_addr_t       wr_addr,
    output bm_pkg::filt_data_t [bm_pkg::NUM_FILTERS-1:0] wr_data,
    output logic                     ready
);

    localparam int TAP_W = $clog2(bm_pkg::KERNEL_TAPS);

    logic                    load_d;
    logic                    load_start;
    logic                    armed;          // waiting for tap 0
    logic                    in_vld;
    logic                    f_start;
    logic [TAP_W-1:0]        kpos;
    logic [TAP_W-1:0]        kpos_use;
    logic                    kcommit;
    logic [bm_pkg::W_CHANNEL+1:0] kernel_cnt;
    bm_pkg::filt_addr_t      last_addr;
    bm_pkg::filt_data_t [bm_pkg::NUM_FILTERS-1:0] acc;

    assign load_start = load & ~load_d;
    assign in_vld     = load & read_data_vld;
    assign f_start    = in_vld & (armed | load_start);

    assign kpos_use = f_start ? '0 : kpos;
    assign kcommit  = in_vld && (kpos_use == TAP_W'(bm_pkg::KERNEL_TAPS - 1));

    // four kernels per input channel
    assign kernel_cnt = {channel, 2'b00};
    assign last_addr  = bm_pkg::filt_addr_t'(kernel_cnt - 1'b1);

    // ----------------------------------------
    // arming and tap position
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_d <= 1'b0;
            armed  <= 1'b0;
            kpos   <= '0;
        end else begin
            load_d <= load;

            if (load_start && !read_data_vld) begin
                armed <= 1'b1;
            end else if (f_start) begin
                armed <= 1'b0;
            end

            if (in_vld) begin
                kpos <= kcommit ? '0 : kpos_use + 1'b1;
            end
        end
    end

    // byte n of the beat lands in tap slot of lane n
    always_ff @(posedge clk) begin
        if (in_vld) begin
            for (int n = 0; n < bm_pkg::NUM_FILTERS; n++) begin
                acc[n][8*kpos_use +: 8] <= read_data[8*n +: 8];
            end
        end
    end

    assign wr_data = acc;

    // ----------------------------------------
    // commit, address and ready flag
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
            ready   <= 1'b0;
        end else begin
            wr_en <= kcommit;                    // kernel goes out one cycle after tap 8

            if (f_start) begin
                wr_addr <= '0;
            end else if (wr_en) begin
                wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + 1'b1;
            end

            if (load_start) begin
                ready <= 1'b0;                   // new load invalidates the set
            end else if (wr_en && (wr_addr == last_addr)) begin
                ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/buffer_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_manager (
    input  wire                     clk,
    input  wire                     rstn,

    input  wire bm_pkg::layer_cfg_t cfg,
    input  wire                     q_load_ifm,
    input  wire                     q_load_filter,
    input  wire                     q_fm_buf_switch,

    // axi read stream
    input  wire bm_pkg::axi_data_t  read_data,
    input  wire                     read_data_vld,

    // feature maps
    input  wire bm_pkg::fm_wr_t     ofm_wr,
    input  wire bm_pkg::fm_rd_t     tap_rd,
    output bm_pkg::fm_data_t        tap_rdata,
    output logic                    ofm_done,

    // filters to the pe array
    output logic                    fb_req_possible,
    input  wire                     fb_req,
    input  wire bm_pkg::filt_addr_t fb_addr,
    output bm_pkg::filt_data_t      fb_data0,
    output bm_pkg::filt_data_t      fb_data1,
    output bm_pkg::filt_data_t      fb_data2,
    output bm_pkg::filt_data_t      fb_data3
);

    bm_pkg::fm_wr_t      load_wr;
    logic                load_active;

    logic                filt_wr_en;
    bm_pkg::filt_addr_t  filt_wr_addr;
    bm_pkg::filt_data_t [bm_pkg::NUM_FILTERS-1:0] filt_wr_data;
    bm_pkg::filt_data_t  filt_rdata [bm_pkg::NUM_FILTERS];

    // ----------------------------------------
    // feature-map side
    // ----------------------------------------
    ifm_axi_loader u_ifm_loader (
        .clk           (clk),
        .rstn          (rstn),
        .load          (q_load_ifm),
        .read_data     (read_data),
        .read_data_vld (read_data_vld),
        .ifm_wr        (load_wr),
        .active        (load_active)
    );

    fm_pingpong u_fm_pingpong (
        .clk         (clk),
        .rstn        (rstn),
        .cfg         (cfg),
        .buf_switch  (q_fm_buf_switch),
        .load_wr     (load_wr),
        .load_active (load_active),
        .ofm_wr      (ofm_wr),
        .tap_rd      (tap_rd),
        .tap_rdata   (tap_rdata),
        .ofm_done    (ofm_done)
    );

    // ----------------------------------------
    // filter side
    // ----------------------------------------
    filter_packer u_filter_packer (
        .clk           (clk),
        .rstn          (rstn),
        .load          (q_load_filter),
        .channel       (cfg.channel),
        .read_data     (read_data),
        .read_data_vld (read_data_vld),
        .wr_en         (filt_wr_en),
        .wr_addr       (filt_wr_addr),
        .wr_data       (filt_wr_data),
        .ready         (fb_req_possible)
    );

    for (genvar n = 0; n < bm_pkg::NUM_FILTERS; n++) begin : g_filt_buf
        sdp_ram #(
            .AW (bm_pkg::FILT_AW),
            .DW (bm_pkg::FILT_DW)
        ) u_filt_ram (
            .clk     (clk),
            .wr_en   (filt_wr_en),
            .wr_addr (filt_wr_addr),
            .wr_data (filt_wr_data[n]),
            .rd_en   (fb_req),
            .rd_addr (fb_addr),
            .rd_data (filt_rdata[n])
        );
    end

    assign fb_data0 = filt_rdata[0];
    assign fb_data1 = filt_rdata[1];
    assign fb_data2 = filt_rdata[2];
    assign fb_data3 = filt_rdata[3];

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    localparam real CLK_PERIOD   = 40.0;
    localparam int  RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;    // released on a rising edge
    end

endmodule

`default_nettype wire

// ==== tests/tb_buffer_manager.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_buffer_manager;

    localparam int IFM_WORDS       = 64;
    localparam int OFM_MAX_WORDS   = 72;   // largest layer below is the 3x2x3 upsample
    localparam int FILT_CHANNEL    = 2;
    localparam int FILT_KERNELS    = FILT_CHANNEL * bm_pkg::NUM_FILTERS;
    localparam int FILT_BEATS      = FILT_KERNELS * bm_pkg::KERNEL_TAPS;
    localparam int READY_WAIT_MAX  = 8;
    localparam int WATCHDOG_CYCLES = (IFM_WORDS + FILT_BEATS) * 4 + 2000;

    logic                clk;
    logic                rstn;

    bm_pkg::layer_cfg_t  cfg;
    logic                q_load_ifm;
    logic                q_load_filter;
    logic                q_fm_buf_switch;
    bm_pkg::axi_data_t   read_data;
    logic                read_data_vld;
    bm_pkg::fm_wr_t      ofm_wr;
    bm_pkg::fm_rd_t      tap_rd;
    bm_pkg::fm_data_t    tap_rdata;
    logic                ofm_done;
    logic                fb_req_possible;
    logic                fb_req;
    bm_pkg::filt_addr_t  fb_addr;
    bm_pkg::filt_data_t  fb_data0;
    bm_pkg::filt_data_t  fb_data1;
    bm_pkg::filt_data_t  fb_data2;
    bm_pkg::filt_data_t  fb_data3;

    integer              seed = 72830;

    // buffer models indexed by physical buffer
    bm_pkg::fm_data_t    fm_model [2][bm_pkg::FM_DEPTH];
    int                  ifm_buf = 0;
    bm_pkg::axi_data_t   filt_beats [FILT_BEATS];

    bm_pkg::fm_data_t    fm_expect [$];
    bm_pkg::filt_data_t  filt_expect [$];
    logic                fm_due = 1'b0;
    logic                filt_due = 1'b0;
    int                  done_count = 0;

    tb_clock_gen u_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    buffer_manager uut (
        .clk             (clk),
        .rstn            (rstn),
        .cfg             (cfg),
        .q_load_ifm      (q_load_ifm),
        .q_load_filter   (q_load_filter),
        .q_fm_buf_switch (q_fm_buf_switch),
        .read_data       (read_data),
        .read_data_vld   (read_data_vld),
        .ofm_wr          (ofm_wr),
        .tap_rd          (tap_rd),
        .tap_rdata       (tap_rdata),
        .ofm_done        (ofm_done),
        .fb_req_possible (fb_req_possible),
        .fb_req          (fb_req),
        .fb_addr         (fb_addr),
        .fb_data0        (fb_data0),
        .fb_data1        (fb_data1),
        .fb_data2        (fb_data2),
        .fb_data3        (fb_data3)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic bm_pkg::fm_addr_t ofm_last_addr(bm_pkg::layer_cfg_t c);
        int w;
        int h;
        int total;
        w = int'(c.width);
        h = int'(c.height);
        if (c.maxpool && (c.maxpool_stride == 2'd2)) begin
            w = w / 2;
            h = h / 2;
        end else if (c.upsample) begin
            w = w * 2;
            h = h * 2;
        end
        total = w * h * int'(c.channel_out);
        return bm_pkg::fm_addr_t'(total - 1);
    endfunction

    // lane word of one kernel with tap t in byte t
    function automatic bm_pkg::filt_data_t pack_kernel(int kernel, int lane);
        bm_pkg::filt_data_t lane_word;
        lane_word = '0;
        for (int t = 0; t < bm_pkg::KERNEL_TAPS; t++) begin
            lane_word[8*t +: 8] = filt_beats[kernel*bm_pkg::KERNEL_TAPS + t][8*lane +: 8];
        end
        return lane_word;
    endfunction

    // ----------------------------------------
    // failure reporting and compare tasks
    // ----------------------------------------
    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(string what);
        $display("ERROR at %0t: %s", $time, what);
        abort_run();
    endtask

    task automatic check_fm(bm_pkg::fm_data_t actual, bm_pkg::fm_data_t expected, string name);
        if (actual !== expected) begin
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_filt(bm_pkg::filt_data_t actual, bm_pkg::filt_data_t expected,
                              string name);
        if (actual !== expected) begin
            $display("FAILED t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(logic actual, logic expected, string name);
        if (actual !== expected) begin
            $display("FAILED t=%0t %s: got %b, expected %b", $time, name, actual, expected);
            abort_run();
        end
    endtask

    // ----------------------------------------
    // compare process on the falling edge
    // ----------------------------------------
    always @(negedge clk) begin
        bm_pkg::fm_data_t   fm_exp;
        bm_pkg::filt_data_t lane_exp [bm_pkg::NUM_FILTERS];

        check_bit(ofm_done, ofm_wr.en && (ofm_wr.addr == ofm_last_addr(cfg)), "ofm_done");
        if (ofm_done === 1'b1) begin
            done_count++;
        end

        if (fm_due) begin
            if (fm_expect.size() == 0) begin
                report_problem("tap data came back with no read outstanding");
            end else begin
                fm_exp = fm_expect.pop_front();
                check_fm(tap_rdata, fm_exp, "tap_rdata");
            end
        end

        if (filt_due) begin
            if (filt_expect.size() < bm_pkg::NUM_FILTERS) begin
                report_problem("filter data came back with no read outstanding");
            end else begin
                for (int n = 0; n < bm_pkg::NUM_FILTERS; n++) begin
                    lane_exp[n] = filt_expect.pop_front();
                end
                check_filt(fb_data0, lane_exp[0], "fb_data0");
                check_filt(fb_data1, lane_exp[1], "fb_data1");
                check_filt(fb_data2, lane_exp[2], "fb_data2");
                check_filt(fb_data3, lane_exp[3], "fb_data3");
            end
        end

        // a request seen now returns after the next edge
        fm_due   = (tap_rd.en === 1'b1);
        filt_due = (fb_req === 1'b1);
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------
    task automatic load_ifm();
        int sent;
        bm_pkg::axi_data_t word;
        sent = 0;
        @(posedge clk);
        q_load_ifm    <= 1'b1;
        read_data_vld <= 1'b0;
        while (sent < IFM_WORDS) begin
            @(posedge clk);
            if (($random(seed) & 3) == 0) begin
                read_data_vld <= 1'b0;        // gap
            end else begin
                word = $random(seed);
                read_data     <= word;
                read_data_vld <= 1'b1;
                fm_model[0][sent] = word;
                sent++;
            end
        end
        @(posedge clk);
        read_data_vld <= 1'b0;
        repeat (2) @(posedge clk);
        q_load_ifm <= 1'b0;
    endtask

    task automatic read_taps(int count);
        for (int a = 0; a < count; a++) begin
            @(posedge clk);
            tap_rd.en   <= 1'b1;
            tap_rd.addr <= bm_pkg::fm_addr_t'(a);
            fm_expect.push_back(fm_model[ifm_buf][a]);
        end
        @(posedge clk);
        tap_rd.en <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic run_ofm_layer(int w, int h, int ch_out, logic mp, logic up);
        bm_pkg::layer_cfg_t c;
        bm_pkg::fm_addr_t   last;
        bm_pkg::fm_data_t   word;
        c = '0;
        c.width          = bm_pkg::size_t'(w);
        c.height         = bm_pkg::size_t'(h);
        c.channel        = bm_pkg::chan_t'(FILT_CHANNEL);
        c.channel_out    = bm_pkg::chan_t'(ch_out);
        c.maxpool        = mp;
        c.maxpool_stride = mp ? 2'd2 : 2'd0;
        c.upsample       = up;
        last = ofm_last_addr(c);
        @(posedge clk);
        cfg <= c;
        done_count = 0;
        for (int a = 0; a <= int'(last); a++) begin
            @(posedge clk);
            word = $random(seed);
            ofm_wr.en   <= 1'b1;
            ofm_wr.addr <= bm_pkg::fm_addr_t'(a);
            ofm_wr.data <= word;
            fm_model[1 - ifm_buf][a] = word;
        end
        @(posedge clk);
        ofm_wr.en <= 1'b0;
        @(negedge clk);
        if (done_count != 1) begin
            report_problem($sformatf("ofm_done pulsed %0d times in one layer", done_count));
        end
    endtask

    task automatic switch_buffers();
        @(posedge clk);
        q_fm_buf_switch <= 1'b1;
        @(posedge clk);
        q_fm_buf_switch <= 1'b0;
        ifm_buf = 1 - ifm_buf;
    endtask

    task automatic load_filters();
        int sent;
        int waited;
        bm_pkg::axi_data_t word;
        sent = 0;
        @(posedge clk);
        q_load_filter <= 1'b1;
        read_data_vld <= 1'b0;
        while (sent < FILT_BEATS) begin
            @(posedge clk);
            if (($random(seed) & 3) == 0) begin
                read_data_vld <= 1'b0;
            end else begin
                word = $random(seed);
                read_data     <= word;
                read_data_vld <= 1'b1;
                filt_beats[sent] = word;
                sent++;
            end
            @(negedge clk);
            check_bit(fb_req_possible, 1'b0, "fb_req_possible");   // not before the last beat
        end
        @(posedge clk);
        read_data_vld <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (fb_req_possible !== 1'b1) begin
            if (waited == READY_WAIT_MAX) begin
                report_problem("fb_req_possible never rose after the last filter beat");
            end
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        q_load_filter <= 1'b0;
    endtask

    task automatic read_filters();
        for (int k = 0; k < FILT_KERNELS; k++) begin
            @(posedge clk);
            fb_req  <= 1'b1;
            fb_addr <= bm_pkg::filt_addr_t'(k);
            for (int n = 0; n < bm_pkg::NUM_FILTERS; n++) begin
                filt_expect.push_back(pack_kernel(k, n));
            end
        end
        @(posedge clk);
        fb_req <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic restart_filter_load();
        @(negedge clk);
        check_bit(fb_req_possible, 1'b1, "fb_req_possible");
        @(posedge clk);
        q_load_filter <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit(fb_req_possible, 1'b0, "fb_req_possible");
        @(posedge clk);
        q_load_filter <= 1'b0;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        cfg             = '0;
        cfg.channel     = bm_pkg::chan_t'(FILT_CHANNEL);
        q_load_ifm      = 1'b0;
        q_load_filter   = 1'b0;
        q_fm_buf_switch = 1'b0;
        read_data       = '0;
        read_data_vld   = 1'b0;
        ofm_wr          = '0;
        tap_rd          = '0;
        fb_req          = 1'b0;
        fb_addr         = '0;

        // reset state during and just after reset
        @(negedge clk);
        while (rstn !== 1'b1) begin
            check_bit(fb_req_possible, 1'b0, "fb_req_possible");
            check_bit(ofm_done, 1'b0, "ofm_done");
            @(negedge clk);
        end
        repeat (3) begin
            check_bit(fb_req_possible, 1'b0, "fb_req_possible");
            @(negedge clk);
        end

        load_ifm();
        read_taps(IFM_WORDS);

        run_ofm_layer(4, 4, 2, 1'b0, 1'b0);   // plain layer of 32 words
        run_ofm_layer(8, 6, 2, 1'b1, 1'b0);   // maxpool by 2 gives 24 words
        run_ofm_layer(3, 2, 3, 1'b0, 1'b1);   // upsample by 2 gives 72 words

        switch_buffers();
        read_taps(OFM_MAX_WORDS);             // ofm data now on the tap
        switch_buffers();
        read_taps(IFM_WORDS);

        load_filters();
        read_filters();
        restart_filter_load();

        if (fm_expect.size() != 0 || filt_expect.size() != 0) begin
            report_problem("some reads never returned data");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run is stuck",
                 WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/bm_pkg.sv
source/sdp_ram.sv
source/ifm_axi_loader.sv
source/fm_pingpong.sv
source/filter_packer.sv
source/buffer_manager.sv
tests/tb_clock_gen.sv
tests/tb_buffer_manager.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_buffer_manager
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation finished: PASS

SIM_BIN   = $(BUILD_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
